/* src/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// geometry of the 4 KiB four-way cache
	localparam int WORD_PER_LINE = 8;
	localparam int SET_ASSOC = 4;
	localparam int CACHE_SIZE = 4096;
	localparam int LINE_WORD_OFFSET = $clog2(WORD_PER_LINE);
	localparam int LINE_BYTE_OFFSET = LINE_WORD_OFFSET + 2;
	localparam int SET_NUM = CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC);
	localparam int INDEX_WIDTH = $clog2(SET_NUM);
	localparam int TAG_WIDTH = 32 - INDEX_WIDTH - LINE_BYTE_OFFSET;
	localparam int LRU_WIDTH = SET_ASSOC - 1;
	localparam int WAY_WIDTH = $clog2(SET_ASSOC);

	typedef logic [31:0] word_t;
	typedef word_t [WORD_PER_LINE-1:0] line_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [LINE_WORD_OFFSET-1:0] offset_t;
	typedef logic [WAY_WIDTH-1:0] way_t;
	typedef logic [LRU_WIDTH-1:0] lru_t;

	typedef struct packed {
		logic valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	// be of zero marks a load
	typedef struct packed {
		word_t addr;
		logic [3:0] be;
		word_t wdata;
	} cache_req_t;

	typedef struct packed {
		word_t addr;
		line_t line;
	} mem_write_req_t;

	function automatic index_t addr_index(input word_t addr);
		return addr[LINE_BYTE_OFFSET +: INDEX_WIDTH];
	endfunction

	function automatic logic [TAG_WIDTH-1:0] addr_tag(input word_t addr);
		return addr[31 -: TAG_WIDTH];
	endfunction

	function automatic offset_t addr_offset(input word_t addr);
		return addr[2 +: LINE_WORD_OFFSET];
	endfunction

	function automatic word_t byte_merge(input word_t old_word, input word_t new_word,
			input logic [3:0] be);
		word_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				merged[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// bit 1 is the root, bit 0 picks within ways 0/1, bit 2 within ways 2/3
	function automatic way_t plru_victim(input lru_t bits);
		if (bits[1]) begin
			return bits[0] ? way_t'(0) : way_t'(1);
		end
		return bits[2] ? way_t'(2) : way_t'(3);
	endfunction

	// both levels end up pointing at the other half
	function automatic lru_t plru_touch(input lru_t bits, input way_t way);
		lru_t upd;
		upd = bits;
		upd[1] = way[1];
		if (way[1]) begin
			upd[2] = way[0];
		end else begin
			upd[0] = way[0];
		end
		return upd;
	endfunction

endpackage

`default_nettype wire

/* src/sync_ram.sv */
`default_nettype none

module sync_ram #(
	parameter int DEPTH = dcache_pkg::SET_NUM,
	parameter type entry_t = logic [31:0]
) (
	input wire logic i_clk,
	input wire logic i_wen,
	input wire dcache_pkg::index_t i_waddr,
	input wire entry_t i_wdata,
	input wire dcache_pkg::index_t i_raddr,
	output entry_t o_rdata
);

	entry_t r_mem [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			r_mem[i_waddr] <= i_wdata;
		end
		// same-address write gives the old entry here
		o_rdata <= r_mem[i_raddr];
	end

endmodule

`default_nettype wire

/* src/plru_table.sv */
`default_nettype none

module plru_table (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire dcache_pkg::index_t i_index,
	input wire logic i_touch,
	input wire dcache_pkg::way_t i_touch_way,
	output dcache_pkg::way_t o_victim
);
	import dcache_pkg::*;

	// one tree per set
	lru_t r_bits [SET_NUM];

	assign o_victim = plru_victim(r_bits[i_index]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SET_NUM; s++) begin
				r_bits[s] <= '0;
			end
		end else if (i_touch) begin
			r_bits[i_index] <= plru_touch(r_bits[i_index], i_touch_way);
		end
	end

	// a touched way is never the next victim of its set
	a_touch_away: assert property (@(posedge i_clk) disable iff (i_rst)
		i_touch |=> plru_victim(r_bits[$past(i_index)]) != $past(i_touch_way));

endmodule

`default_nettype wire

/* src/refill_buffer.sv */
`default_nettype none

module refill_buffer (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_start,
	input wire dcache_pkg::offset_t i_start_offset,
	input wire dcache_pkg::offset_t i_target_offset,
	input wire logic [3:0] i_store_be,
	input wire dcache_pkg::word_t i_store_data,
	input wire logic i_mem_rvalid,
	input wire dcache_pkg::word_t i_mem_rdata,
	input wire logic i_mem_rlast,
	output dcache_pkg::line_t o_line,
	output logic o_word_hit,
	output dcache_pkg::word_t o_word,
	output logic o_done
);
	import dcache_pkg::*;

	// word position of the next beat
	offset_t r_cnt;
	logic r_active;
	logic r_done;
	line_t r_line;
	word_t w_beat;

	assign o_word_hit = i_mem_rvalid && (r_cnt == i_target_offset);
	// a load has no enabled bytes, so the beat passes unchanged
	assign o_word = byte_merge(i_mem_rdata, i_store_data, i_store_be);
	assign w_beat = o_word_hit ? o_word : i_mem_rdata;
	assign o_line = r_line;
	assign o_done = r_done;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_cnt <= '0;
			r_active <= 1'b0;
			r_done <= 1'b0;
		end else begin
			r_done <= i_mem_rvalid && i_mem_rlast;
			if (i_start) begin
				r_cnt <= i_start_offset;
				r_active <= 1'b1;
			end else if (i_mem_rvalid) begin
				// wraps inside the line
				r_cnt <= r_cnt + 1'b1;
				if (i_mem_rlast) begin
					r_active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_mem_rvalid) begin
			r_line[r_cnt] <= w_beat;
		end
	end

	a_beat_after_start: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_rvalid |-> r_active);

	// the last beat closes the wrap one word before the start
	a_full_burst: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_rvalid && i_mem_rlast |-> offset_t'(r_cnt + 1'b1) == i_start_offset);

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	input wire dcache_pkg::cache_req_t i_req,
	output logic o_busy,
	output logic o_rvalid,
	output dcache_pkg::word_t o_rdata,
	input wire dcache_pkg::tag_entry_t [dcache_pkg::SET_ASSOC-1:0] i_tag_rdata,
	input wire dcache_pkg::line_t [dcache_pkg::SET_ASSOC-1:0] i_line_rdata,
	output dcache_pkg::index_t o_raddr,
	output logic [dcache_pkg::SET_ASSOC-1:0] o_tag_wen,
	output logic [dcache_pkg::SET_ASSOC-1:0] o_line_wen,
	output dcache_pkg::index_t o_waddr,
	output dcache_pkg::tag_entry_t o_wtag,
	output dcache_pkg::line_t o_wline,
	output logic o_touch,
	output dcache_pkg::way_t o_touch_way,
	output dcache_pkg::index_t o_lru_index,
	input wire dcache_pkg::way_t i_victim,
	output logic o_refill_start,
	output logic [3:0] o_store_be,
	output dcache_pkg::word_t o_store_data,
	input wire logic i_word_hit,
	input wire dcache_pkg::word_t i_word,
	input wire dcache_pkg::line_t i_refill_line,
	input wire logic i_refill_done,
	output logic o_mem_rd,
	output dcache_pkg::word_t o_mem_rd_addr,
	output logic o_mem_wr,
	output dcache_pkg::mem_write_req_t o_mem_wreq,
	input wire logic i_mem_wdone
);
	import dcache_pkg::*;

	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		WRITEBACK,
		REFILL_WAIT,
		REFILL_WRITE
	} state_t;

	state_t r_state, w_next;
	index_t r_inv_cnt;

	// request in its compare cycle
	logic r_req_valid;
	cache_req_t r_req;

	// miss context, held until the refill lands
	cache_req_t r_miss_req;
	way_t r_victim_way;
	tag_entry_t r_victim_tag;
	line_t r_victim_line;
	logic r_mem_rd;
	logic r_mem_wr;

	logic [SET_ASSOC-1:0] w_way_hit;
	logic [SET_ASSOC-1:0] w_victim_onehot;
	logic w_hit;
	logic w_lookup;
	logic w_miss;
	logic w_is_write;
	way_t w_hit_way;
	offset_t w_offset;
	line_t w_hit_line;
	line_t w_merged_line;
	word_t w_hit_word;

	assign w_lookup = (r_state == IDLE) && r_req_valid;
	assign w_is_write = |r_req.be;
	assign w_offset = addr_offset(r_req.addr);

	// tag compare over all ways
	always_comb begin
		w_hit_way = '0;
		for (int w = 0; w < SET_ASSOC; w++) begin
			w_way_hit[w] = i_tag_rdata[w].valid && (i_tag_rdata[w].tag == addr_tag(r_req.addr));
			if (w_way_hit[w]) begin
				w_hit_way = way_t'(w);
			end
		end
	end

	assign w_hit = |w_way_hit;
	assign w_miss = w_lookup && !w_hit;
	assign w_hit_line = i_line_rdata[w_hit_way];
	assign w_hit_word = byte_merge(w_hit_line[w_offset], r_req.wdata, r_req.be);

	always_comb begin
		w_merged_line = w_hit_line;
		w_merged_line[w_offset] = w_hit_word;
	end

	// writes and misses hold off the next request
	assign o_busy = (r_state != IDLE) || (r_req_valid && (w_is_write || !w_hit));
	assign o_raddr = addr_index(i_req.addr);
	assign o_rvalid = (w_lookup && w_hit) || ((r_state == REFILL_WAIT) && i_word_hit);
	assign o_rdata = (r_state == REFILL_WAIT) ? i_word : w_hit_word;

	// a miss also touches the way it is about to fill
	assign o_lru_index = addr_index(r_req.addr);
	assign o_touch = w_lookup;
	assign o_touch_way = w_hit ? w_hit_way : i_victim;

	assign w_victim_onehot = {{(SET_ASSOC-1){1'b0}}, 1'b1} << r_victim_way;

	// array write port
	always_comb begin
		o_tag_wen = '0;
		o_line_wen = '0;
		o_waddr = addr_index(r_miss_req.addr);
		o_wtag.valid = 1'b1;
		o_wtag.tag = addr_tag(r_miss_req.addr);
		o_wline = i_refill_line;
		case (r_state)
			INVALIDATING: begin
				o_tag_wen = '1;
				o_waddr = r_inv_cnt;
				o_wtag = '0;
			end
			IDLE: begin
				if (w_lookup && w_hit && w_is_write) begin
					o_line_wen = w_way_hit;
					o_waddr = addr_index(r_req.addr);
					o_wline = w_merged_line;
				end
			end
			REFILL_WRITE: begin
				if (i_refill_done) begin
					o_tag_wen = w_victim_onehot;
					o_line_wen = w_victim_onehot;
				end
			end
			default: begin
				o_tag_wen = '0;
			end
		endcase
	end

	// miss FSM
	always_comb begin
		w_next = r_state;
		case (r_state)
			INVALIDATING: begin
				if (r_inv_cnt == index_t'(SET_NUM - 1)) begin
					w_next = IDLE;
				end
			end
			IDLE: begin
				if (w_miss) begin
					w_next = i_tag_rdata[i_victim].valid ? WRITEBACK : REFILL_WAIT;
				end
			end
			WRITEBACK: begin
				if (i_mem_wdone) begin
					w_next = REFILL_WAIT;
				end
			end
			REFILL_WAIT: begin
				if (i_word_hit) begin
					w_next = REFILL_WRITE;
				end
			end
			REFILL_WRITE: begin
				if (i_refill_done) begin
					w_next = IDLE;
				end
			end
			default: begin
				w_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= INVALIDATING;
			r_inv_cnt <= '0;
			r_req_valid <= 1'b0;
			r_mem_rd <= 1'b0;
			r_mem_wr <= 1'b0;
		end else begin
			r_state <= w_next;
			r_req_valid <= i_req_valid && !o_busy;
			// one-cycle pulses on entry to each memory state
			r_mem_wr <= (r_state == IDLE) && (w_next == WRITEBACK);
			r_mem_rd <= (r_state != REFILL_WAIT) && (w_next == REFILL_WAIT);
			if (r_state == INVALIDATING) begin
				r_inv_cnt <= r_inv_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req_valid && !o_busy) begin
			r_req <= i_req;
		end
		if (w_miss) begin
			r_miss_req <= r_req;
			r_victim_way <= i_victim;
			r_victim_tag <= i_tag_rdata[i_victim];
			r_victim_line <= i_line_rdata[i_victim];
		end
	end

	assign o_mem_rd = r_mem_rd;
	assign o_mem_rd_addr = {r_miss_req.addr[31:2], 2'b00};
	assign o_mem_wr = r_mem_wr;
	assign o_mem_wreq = '{
		addr: {r_victim_tag.tag, addr_index(r_miss_req.addr), {LINE_BYTE_OFFSET{1'b0}}},
		line: r_victim_line
	};
	assign o_refill_start = r_mem_rd;
	assign o_store_be = r_miss_req.be;
	assign o_store_data = r_miss_req.wdata;

	a_mem_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_mem_rd && o_mem_wr));

	a_single_hit: assert property (@(posedge i_clk) disable iff (i_rst)
		w_lookup |-> $onehot0(w_way_hit));

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`default_nettype none

module dcache_top (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	input wire dcache_pkg::cache_req_t i_req,
	output logic o_busy,
	output logic o_rvalid,
	output dcache_pkg::word_t o_rdata,
	output logic o_mem_rd,
	output dcache_pkg::word_t o_mem_rd_addr,
	input wire logic i_mem_rvalid,
	input wire dcache_pkg::word_t i_mem_rdata,
	input wire logic i_mem_rlast,
	output logic o_mem_wr,
	output dcache_pkg::mem_write_req_t o_mem_wreq,
	input wire logic i_mem_wdone
);
	import dcache_pkg::*;

	tag_entry_t [SET_ASSOC-1:0] tag_rdata;
	line_t [SET_ASSOC-1:0] line_rdata;
	logic [SET_ASSOC-1:0] tag_wen;
	logic [SET_ASSOC-1:0] line_wen;
	index_t raddr;
	index_t waddr;
	tag_entry_t wtag;
	line_t wline;

	logic touch;
	way_t touch_way;
	index_t lru_index;
	way_t victim;

	logic refill_start;
	logic [3:0] store_be;
	word_t store_data;
	logic word_hit;
	word_t refill_word;
	line_t refill_line;
	logic refill_done;

	for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
		sync_ram #(
			.DEPTH(SET_NUM),
			.entry_t(tag_entry_t)
		) u_tag_ram (
			.i_clk(i_clk),
			.i_wen(tag_wen[w]),
			.i_waddr(waddr),
			.i_wdata(wtag),
			.i_raddr(raddr),
			.o_rdata(tag_rdata[w])
		);

		sync_ram #(
			.DEPTH(SET_NUM),
			.entry_t(line_t)
		) u_line_ram (
			.i_clk(i_clk),
			.i_wen(line_wen[w]),
			.i_waddr(waddr),
			.i_wdata(wline),
			.i_raddr(raddr),
			.o_rdata(line_rdata[w])
		);
	end

	plru_table u_plru (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_index(lru_index),
		.i_touch(touch),
		.i_touch_way(touch_way),
		.o_victim(victim)
	);

	// burst starts at the requested word, so start and target coincide
	refill_buffer u_refill (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(refill_start),
		.i_start_offset(o_mem_rd_addr[LINE_BYTE_OFFSET-1:2]),
		.i_target_offset(o_mem_rd_addr[LINE_BYTE_OFFSET-1:2]),
		.i_store_be(store_be),
		.i_store_data(store_data),
		.i_mem_rvalid(i_mem_rvalid),
		.i_mem_rdata(i_mem_rdata),
		.i_mem_rlast(i_mem_rlast),
		.o_line(refill_line),
		.o_word_hit(word_hit),
		.o_word(refill_word),
		.o_done(refill_done)
	);

	dcache_ctrl u_ctrl (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_busy(o_busy),
		.o_rvalid(o_rvalid),
		.o_rdata(o_rdata),
		.i_tag_rdata(tag_rdata),
		.i_line_rdata(line_rdata),
		.o_raddr(raddr),
		.o_tag_wen(tag_wen),
		.o_line_wen(line_wen),
		.o_waddr(waddr),
		.o_wtag(wtag),
		.o_wline(wline),
		.o_touch(touch),
		.o_touch_way(touch_way),
		.o_lru_index(lru_index),
		.i_victim(victim),
		.o_refill_start(refill_start),
		.o_store_be(store_be),
		.o_store_data(store_data),
		.i_word_hit(word_hit),
		.i_word(refill_word),
		.i_refill_line(refill_line),
		.i_refill_done(refill_done),
		.o_mem_rd(o_mem_rd),
		.o_mem_rd_addr(o_mem_rd_addr),
		.o_mem_wr(o_mem_wr),
		.o_mem_wreq(o_mem_wreq),
		.i_mem_wdone(i_mem_wdone)
	);

endmodule

`default_nettype wire

/* verification/dcache_mem_model.sv */
`default_nettype none

module dcache_mem_model (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_rd,
	input wire dcache_pkg::word_t i_rd_addr,
	output logic o_rvalid,
	output dcache_pkg::word_t o_rdata,
	output logic o_rlast,
	input wire logic i_wr,
	input wire dcache_pkg::mem_write_req_t i_wreq,
	output logic o_wdone
);
	import dcache_pkg::*;

	// 16 KiB of backing store, word addressed
	localparam int MEM_WORDS = 4096;

	word_t r_mem [MEM_WORDS];
	logic [8:0] r_line;
	offset_t r_pos;
	logic [2:0] r_rd_wait;
	logic [3:0] r_beats;
	logic [2:0] r_wr_wait;

	function automatic logic [31:0] advance_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial begin
		logic [31:0] state;
		word_t value;
		state = 32'h4db;
		for (int a = 0; a < MEM_WORDS; a++) begin
			for (int b = 0; b < 32; b++) begin
				state = advance_lfsr(state);
				value[b] = state[0];
			end
			r_mem[a] = value;
		end
	end

	always @(posedge i_clk) begin
		if (i_rst) begin
			o_rvalid <= 1'b0;
			o_rlast <= 1'b0;
			o_rdata <= '0;
			o_wdone <= 1'b0;
			r_rd_wait <= '0;
			r_beats <= '0;
			r_wr_wait <= '0;
		end else begin
			o_rvalid <= 1'b0;
			o_rlast <= 1'b0;
			o_wdone <= 1'b0;
			// burst starts at the requested word and wraps
			if (i_rd) begin
				r_line <= i_rd_addr[13:5];
				r_pos <= i_rd_addr[4:2];
				r_rd_wait <= 3'd3;
			end else if (r_rd_wait != 0) begin
				r_rd_wait <= r_rd_wait - 1'b1;
				if (r_rd_wait == 1) begin
					r_beats <= 4'(WORD_PER_LINE);
				end
			end else if (r_beats != 0) begin
				o_rvalid <= 1'b1;
				o_rdata <= r_mem[{r_line, r_pos}];
				o_rlast <= (r_beats == 1);
				r_pos <= r_pos + 1'b1;
				r_beats <= r_beats - 1'b1;
			end
			if (i_wr) begin
				for (int w = 0; w < WORD_PER_LINE; w++) begin
					r_mem[{i_wreq.addr[13:5], 3'(w)}] <= i_wreq.line[w];
				end
				r_wr_wait <= 3'd4;
			end else if (r_wr_wait != 0) begin
				r_wr_wait <= r_wr_wait - 1'b1;
				if (r_wr_wait == 1) begin
					o_wdone <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	logic i_clk = 1'b0;
	logic i_rst;
	logic i_req_valid;
	cache_req_t i_req;
	logic o_busy;
	logic o_rvalid;
	logic o_mem_rd;
	logic o_mem_wr;
	word_t o_rdata;
	word_t o_mem_rd_addr;
	word_t mem_rdata;
	logic mem_rvalid;
	logic mem_rlast;
	logic mem_wdone;
	mem_write_req_t o_mem_wreq;

	// stimulus table
	cache_req_t reqs[$];
	string names[$];

	// golden memory and shadow of the cache state
	word_t golden [4096];
	logic shadow_valid [SET_NUM][SET_ASSOC];
	logic [TAG_WIDTH-1:0] shadow_tag [SET_NUM][SET_ASSOC];
	// victim half of each set, and the victim way inside each half
	logic victim_upper [SET_NUM];
	logic victim_odd [SET_NUM][2];

	int rd_count;
	int wr_count;
	word_t rd_addr_seen;
	mem_write_req_t wreq_seen;
	int cycles = 0;
	int cycle_limit = 100000;

	always #2 i_clk = ~i_clk;

	dcache_top dut (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req_valid(i_req_valid), .i_req(i_req),
		.o_busy(o_busy), .o_rvalid(o_rvalid), .o_rdata(o_rdata),
		.o_mem_rd(o_mem_rd), .o_mem_rd_addr(o_mem_rd_addr),
		.i_mem_rvalid(mem_rvalid), .i_mem_rdata(mem_rdata), .i_mem_rlast(mem_rlast),
		.o_mem_wr(o_mem_wr), .o_mem_wreq(o_mem_wreq), .i_mem_wdone(mem_wdone)
	);

	dcache_mem_model u_mem (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_rd(o_mem_rd), .i_rd_addr(o_mem_rd_addr),
		.o_rvalid(mem_rvalid), .o_rdata(mem_rdata), .o_rlast(mem_rlast),
		.i_wr(o_mem_wr), .i_wreq(o_mem_wreq), .o_wdone(mem_wdone)
	);

	// memory request monitor
	always @(negedge i_clk) begin
		if (o_mem_rd) begin
			rd_count++;
			rd_addr_seen = o_mem_rd_addr;
		end
		if (o_mem_wr) begin
			wr_count++;
			wreq_seen = o_mem_wreq;
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: no response after %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t apply_byte_enables(input word_t old_w, input word_t new_w,
			input logic [3:0] be);
		word_t mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	// root picks the half, then the leaf of that half picks the way
	function automatic way_t predict_victim(input index_t set);
		logic upper;
		upper = victim_upper[set];
		return {upper, victim_odd[set][upper]};
	endfunction

	// the used way and its half stop being victims
	task automatic mark_used(input index_t set, input way_t way);
		victim_upper[set] = !way[1];
		victim_odd[set][way[1]] = !way[0];
	endtask

	task automatic add_entry(input word_t addr, input logic [3:0] be, input word_t data,
			input string name);
		cache_req_t r;
		r.addr = addr;
		r.be = be;
		r.wdata = data;
		reqs.push_back(r);
		names.push_back(name);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %08h actual %08h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_wreq(input string name, input mem_write_req_t exp,
			input mem_write_req_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic run_request(input int idx);
		cache_req_t req;
		string name;
		index_t set;
		logic [TAG_WIDTH-1:0] tag;
		int hit_way;
		way_t victim;
		logic expect_wb;
		mem_write_req_t exp_wreq;
		word_t exp_word;
		word_t got;
		int latency;
		req = reqs[idx];
		name = names[idx];
		set = req.addr[9:5];
		tag = req.addr[31:10];
		hit_way = -1;
		expect_wb = 1'b0;
		exp_wreq = '0;
		for (int w = 0; w < SET_ASSOC; w++) begin
			if (shadow_valid[set][w] && shadow_tag[set][w] == tag) hit_way = w;
		end
		if (hit_way < 0) begin
			victim = predict_victim(set);
			if (shadow_valid[set][victim]) begin
				expect_wb = 1'b1;
				exp_wreq.addr = {shadow_tag[set][victim], set, 5'b0};
				for (int k = 0; k < WORD_PER_LINE; k++) begin
					exp_wreq.line[k] = golden[{exp_wreq.addr[13:5], 3'(k)}];
				end
			end
			shadow_valid[set][victim] = 1'b1;
			shadow_tag[set][victim] = tag;
			mark_used(set, victim);
		end else begin
			mark_used(set, way_t'(hit_way));
		end
		golden[req.addr[13:2]] = apply_byte_enables(golden[req.addr[13:2]], req.wdata, req.be);
		exp_word = golden[req.addr[13:2]];

		rd_count = 0;
		wr_count = 0;
		@(posedge i_clk);
		i_req_valid <= 1'b1;
		i_req <= req;
		@(negedge i_clk);
		while (o_busy) @(negedge i_clk);
		@(posedge i_clk);
		i_req_valid <= 1'b0;
		latency = 0;
		do begin
			@(negedge i_clk);
			latency++;
		end while (!o_rvalid);
		got = o_rdata;

		check_word(name, exp_word, got);
		// only a read hit leaves the port open while it answers
		check_flag({name, " busy"}, (hit_way < 0) || (req.be != 4'b0000), o_busy);
		if (hit_way >= 0) begin
			if (latency != 1) report_failure({name, ": hit answered late"});
			if (rd_count != 0) report_failure({name, ": hit issued a memory read"});
			if (req.be != 4'b0000) begin
				@(negedge i_clk);
				check_flag({name, " busy released"}, 1'b0, o_busy);
			end
		end else begin
			if (rd_count != 1) report_failure({name, ": miss did not issue one memory read"});
			check_word({name, " read address"}, {req.addr[31:2], 2'b00}, rd_addr_seen);
			if (expect_wb) begin
				if (wr_count != 1) report_failure({name, ": victim was not written back"});
				check_wreq({name, " write-back"}, exp_wreq, wreq_seen);
			end else if (wr_count != 0) begin
				report_failure({name, ": write-back of an invalid victim"});
			end
		end
	endtask

	initial begin
		logic [31:0] state;
		word_t value;
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_req = '0;
		state = 32'h4db;
		for (int a = 0; a < 4096; a++) begin
			for (int b = 0; b < 32; b++) begin
				state = lfsr_next(state);
				value[b] = state[0];
			end
			golden[a] = value;
		end
		for (int s = 0; s < SET_NUM; s++) begin
			// a cleared tree names way 3, and way 1 within the lower half
			victim_upper[s] = 1'b1;
			victim_odd[s][0] = 1'b1;
			victim_odd[s][1] = 1'b1;
			for (int w = 0; w < SET_ASSOC; w++) shadow_valid[s][w] = 1'b0;
		end

		add_entry(32'h0000_0104, 4'b0000, 32'h0, "miss_read_a");
		add_entry(32'h0000_0248, 4'b0000, 32'h0, "miss_read_b");
		add_entry(32'h0000_0108, 4'b0000, 32'h0, "hit_read_a");
		add_entry(32'h0000_011c, 4'b0000, 32'h0, "hit_read_a_end");
		add_entry(32'h0000_010c, 4'b0110, 32'ha5a5_5a5a, "write_hit_partial");
		add_entry(32'h0000_010c, 4'b0000, 32'h0, "read_after_write_hit");
		add_entry(32'h0000_0334, 4'b1001, 32'h1122_3344, "write_miss_merge");
		add_entry(32'h0000_0334, 4'b0000, 32'h0, "read_after_write_miss");
		add_entry(32'h0000_0004, 4'b0000, 32'h0, "set0_line_a");
		add_entry(32'h0000_040c, 4'b1111, 32'hdead_beef, "set0_store_b");
		add_entry(32'h0000_0818, 4'b0000, 32'h0, "set0_line_c");
		add_entry(32'h0000_0c1c, 4'b0000, 32'h0, "set0_line_d");
		add_entry(32'h0000_0000, 4'b0000, 32'h0, "set0_touch_a");
		add_entry(32'h0000_1010, 4'b0000, 32'h0, "set0_fifth_evicts");
		add_entry(32'h0000_1404, 4'b0011, 32'h0000_c0de, "set0_sixth_evicts");
		add_entry(32'h0000_040c, 4'b0000, 32'h0, "reread_b");
		add_entry(32'h0000_081c, 4'b0000, 32'h0, "reread_c");
		add_entry(32'h0000_0c00, 4'b0000, 32'h0, "reread_d");
		cycle_limit = reqs.size() * 60 + SET_NUM + 8;

		repeat (4) @(posedge i_clk);
		i_rst <= 1'b0;
		// the sweep holds the port for one cycle per set
		for (int s = 0; s < SET_NUM; s++) begin
			@(negedge i_clk);
			check_flag("invalidation busy", 1'b1, o_busy);
		end
		@(negedge i_clk);
		check_flag("invalidation done", 1'b0, o_busy);
		for (int i = 0; i < reqs.size(); i++) begin
			run_request(i);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* dcache.f */
src/dcache_pkg.sv
src/sync_ram.sv
src/plru_table.sv
src/refill_buffer.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= dcache_tb
RTL_TOP ?= dcache_top
FILELIST ?= dcache.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
